// File: common/sdspi_params.svh
`ifndef SDSPI_PARAMS_SVH
`define SDSPI_PARAMS_SVH

// FIFO depth is 2**SDSPI_FIFO_LOG2 bytes
`define SDSPI_FIFO_LOG2 9

// register byte offsets
`define SDSPI_ADDR_SCALER 12'h000
`define SDSPI_ADDR_WDOG   12'h008
`define SDSPI_ADDR_CTRL   12'h044
`define SDSPI_ADDR_TXDATA 12'h048
`define SDSPI_ADDR_RXDATA 12'h04C

`define SDSPI_IDLE_BYTE 8'hFF   // sent when the tx FIFO runs dry

`endif

// File: common/sdspi_pkg.sv
`default_nettype none

`include "sdspi_params.svh"

package sdspi_pkg;

    typedef logic [7:0] byte_t;                         // one serial byte
    typedef logic [`SDSPI_FIFO_LOG2:0] fifo_cnt_t;      // 0 .. depth
    typedef logic [15:0] scaler_t;                      // sclk half-period in i_clk cycles
    typedef logic [15:0] wdog_t;                        // start-bit wait, sclk periods
    typedef logic [15:0] byte_cnt_t;
    typedef logic [11:0] reg_addr_t;
    typedef logic [31:0] reg_data_t;
    typedef logic [6:0] crc7_t;

    // code is visible in CTRL bits 6:4
    typedef enum logic [2:0] {
        idle      = 3'd0,
        wait_edge = 3'd1,
        send_data = 3'd2,
        recv_data = 3'd3,
        ending    = 3'd5
    } spi_state_t;

endpackage

`default_nettype wire

// File: design/byte_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module byte_fifo #(
    parameter int LOG2_DEPTH = 4
) (
    input  wire                   i_clk,
    input  wire                   i_nrst,
    input  wire                   i_push,
    input  wire sdspi_pkg::byte_t i_wdata,
    input  wire                   i_pop,
    output sdspi_pkg::byte_t      o_rdata,
    output logic                  o_empty,
    output logic                  o_full,
    output sdspi_pkg::fifo_cnt_t  o_count
);

    localparam int DEPTH = 1 << LOG2_DEPTH;

    sdspi_pkg::byte_t      mem [DEPTH];
    logic [LOG2_DEPTH-1:0] wr_ptr;
    logic [LOG2_DEPTH-1:0] rd_ptr;
    logic [LOG2_DEPTH:0]   count;
    logic                  do_push;
    logic                  do_pop;

    assign o_full  = count[LOG2_DEPTH];                    // count == DEPTH
    assign o_empty = (count == '0);
    assign o_count = sdspi_pkg::fifo_cnt_t'(count);
    assign o_rdata = mem[rd_ptr];                          // show-ahead

    assign do_push = i_push & ~o_full;
    assign do_pop  = i_pop & ~o_empty;

    always_ff @(posedge i_clk) begin
        if (do_push) begin
            mem[wr_ptr] <= i_wdata;
        end
    end

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: spi_engine/sclk_divider.sv
`timescale 1ns/1ps
`default_nettype none

module sclk_divider (
    input  wire                     i_clk,
    input  wire                     i_nrst,
    input  wire sdspi_pkg::scaler_t i_scaler,
    input  wire                     i_restart,
    output logic                    o_level,
    output logic                    o_rise,
    output logic                    o_fall
);

    sdspi_pkg::scaler_t cnt;

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            cnt     <= '0;
            o_level <= 1'b0;
            o_rise  <= 1'b0;
            o_fall  <= 1'b0;
        end else begin
            o_rise <= 1'b0;
            o_fall <= 1'b0;
            if (i_restart) begin
                cnt <= '0;                                 // new scaler written
            end else if (i_scaler != '0) begin
                if (cnt == i_scaler - 16'd1) begin
                    cnt     <= '0;
                    o_level <= ~o_level;
                    o_rise  <= ~o_level;
                    o_fall  <= o_level;
                end else begin
                    cnt <= cnt + 16'd1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: spi_engine/spi_byte_engine.sv
`timescale 1ns/1ps
`default_nettype none

`include "sdspi_params.svh"

module spi_byte_engine (
    input  wire                       i_clk,
    input  wire                       i_nrst,
    input  wire                       i_rise,
    input  wire                       i_fall,
    input  wire                       i_level,
    input  wire                       i_ctrl_we,
    input  wire sdspi_pkg::reg_data_t i_ctrl_wdata,
    input  wire sdspi_pkg::wdog_t     i_wdog,
    input  wire sdspi_pkg::byte_t     i_tx_data,
    input  wire                       i_tx_valid,
    input  wire                       i_miso,
    output logic                      o_tx_pop,
    output logic                      o_rx_push,
    output sdspi_pkg::byte_t          o_rx_data,
    output sdspi_pkg::spi_state_t     o_state,
    output sdspi_pkg::byte_cnt_t      o_bytes_left,
    output logic                      o_gen_crc,
    output logic                      o_rx_ena,
    output logic                      o_rx_synced,
    output logic                      o_sclk,
    output logic                      o_mosi,
    output logic                      o_cs_n
);

    sdspi_pkg::wdog_t  wdog_cnt;
    sdspi_pkg::byte_t  shift_reg;
    sdspi_pkg::byte_t  shift_next;
    sdspi_pkg::byte_t  tx_val;
    sdspi_pkg::byte_t  load_byte;
    sdspi_pkg::crc7_t  crc7;
    sdspi_pkg::crc7_t  crc7_next;
    logic [2:0]        bit_cnt;
    logic              cs;
    logic              crc_fb;
    logic              more_bytes;
    logic              byte_done;

    // CRC7 over x^7 + x^3 + 1 fed with the bit on the line
    assign crc_fb    = crc7[6] ^ shift_reg[7];
    assign crc7_next = {crc7[5:3], crc7[2] ^ crc_fb, crc7[1:0], crc_fb};

    assign shift_next = {shift_reg[6:0], o_rx_ena ? i_miso : 1'b1};
    assign load_byte  = i_tx_valid ? i_tx_data : `SDSPI_IDLE_BYTE;
    assign more_bytes = (o_bytes_left != '0);
    assign byte_done  = i_rise && (bit_cnt == 3'd0);

    assign o_tx_pop = !o_rx_ena && more_bytes && i_tx_valid
                      && ((o_state == sdspi_pkg::idle)
                          || (o_state == sdspi_pkg::send_data && byte_done));

    assign o_sclk = i_level & cs;
    assign o_mosi = o_rx_ena | shift_reg[7];               // high while receiving
    assign o_cs_n = ~cs;

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            o_state      <= sdspi_pkg::idle;
            o_bytes_left <= '0;
            o_gen_crc    <= 1'b0;
            o_rx_ena     <= 1'b0;
            o_rx_synced  <= 1'b0;
            o_rx_push    <= 1'b0;
            o_rx_data    <= '0;
            wdog_cnt     <= '0;
            shift_reg    <= '1;
            tx_val       <= '1;
            crc7         <= '0;
            bit_cnt      <= '0;
            cs           <= 1'b0;
        end else begin
            o_rx_push <= 1'b0;
            // tx shifts on falling edges, rx samples on rising edges
            if (cs && ((i_fall && !o_rx_ena) || (i_rise && o_rx_ena))) begin
                shift_reg <= shift_next;
            end
            if (i_fall && cs) begin
                if (bit_cnt != 3'd0) begin
                    if (!o_rx_ena || o_rx_synced) begin
                        bit_cnt <= bit_cnt - 3'd1;
                    end
                end else begin
                    cs <= 1'b0;                            // dropped unless next byte reloads
                end
            end
            if (i_rise && cs && (!o_rx_ena || o_rx_synced)) begin
                crc7 <= crc7_next;
            end

            case (o_state)
                sdspi_pkg::idle: begin
                    wdog_cnt <= i_wdog;
                    if (more_bytes) begin
                        tx_val       <= load_byte;
                        o_bytes_left <= o_bytes_left - 16'd1;
                        crc7         <= '0;
                        o_state      <= sdspi_pkg::wait_edge;
                    end
                end
                sdspi_pkg::wait_edge: begin
                    if (i_fall) begin
                        cs        <= 1'b1;
                        bit_cnt   <= 3'd7;
                        shift_reg <= o_rx_ena ? 8'h00 : tx_val;
                        o_state   <= o_rx_ena ? sdspi_pkg::recv_data : sdspi_pkg::send_data;
                    end
                end
                sdspi_pkg::send_data: begin
                    if (byte_done) begin
                        if (more_bytes) begin
                            tx_val       <= load_byte;
                            o_bytes_left <= o_bytes_left - 16'd1;
                            o_state      <= sdspi_pkg::wait_edge;
                        end else if (o_gen_crc) begin
                            tx_val    <= {crc7_next, 1'b1};   // includes the last data bit
                            o_gen_crc <= 1'b0;
                            o_state   <= sdspi_pkg::wait_edge;
                        end else begin
                            o_state <= sdspi_pkg::ending;
                        end
                    end
                end
                sdspi_pkg::recv_data: begin
                    if (i_rise) begin
                        if (!o_rx_synced) begin
                            o_rx_synced <= ~i_miso;        // low bit is the byte's msb
                            if (wdog_cnt != '0) begin
                                wdog_cnt <= wdog_cnt - 16'd1;
                            end else if (i_wdog != '0) begin
                                o_rx_synced <= 1'b1;       // give up waiting
                            end
                        end
                        if (bit_cnt == 3'd0) begin
                            o_rx_push <= 1'b1;
                            o_rx_data <= shift_next;
                            if (more_bytes) begin
                                o_bytes_left <= o_bytes_left - 16'd1;
                                o_state      <= sdspi_pkg::wait_edge;
                            end else begin
                                o_state <= sdspi_pkg::ending;
                            end
                        end
                    end
                end
                sdspi_pkg::ending: begin
                    if (!cs) begin
                        o_state <= sdspi_pkg::idle;
                    end
                end
                default: o_state <= sdspi_pkg::idle;
            endcase

            if (i_ctrl_we) begin
                o_gen_crc    <= i_ctrl_wdata[7];
                o_rx_ena     <= i_ctrl_wdata[8];
                o_rx_synced  <= i_ctrl_wdata[9];
                o_bytes_left <= i_ctrl_wdata[31:16];   // nonzero starts a transfer
            end
        end
    end

endmodule

`default_nettype wire

// File: design/sdspi_regs.sv
`timescale 1ns/1ps
`default_nettype none

`include "sdspi_params.svh"

module sdspi_regs (
    input  wire                        i_clk,
    input  wire                        i_nrst,
    input  wire                        i_req_valid,
    input  wire sdspi_pkg::reg_addr_t  i_req_addr,
    input  wire                        i_req_write,
    input  wire sdspi_pkg::reg_data_t  i_req_wdata,
    output logic                       o_req_ready,
    output logic                       o_resp_valid,
    output sdspi_pkg::reg_data_t       o_resp_rdata,
    input  wire                        i_resp_ready,
    input  wire                        i_tx_full,
    input  wire sdspi_pkg::byte_t      i_rx_head,
    input  wire                        i_rx_empty,
    input  wire sdspi_pkg::spi_state_t i_state,
    input  wire sdspi_pkg::byte_cnt_t  i_bytes_left,
    input  wire                        i_gen_crc,
    input  wire                        i_rx_ena,
    input  wire                        i_rx_synced,
    output logic                       o_tx_push,
    output sdspi_pkg::byte_t           o_tx_data,
    output logic                       o_rx_pop,
    output sdspi_pkg::scaler_t         o_scaler,
    output logic                       o_scaler_we,
    output sdspi_pkg::wdog_t           o_wdog,
    output logic                       o_ctrl_we,
    output sdspi_pkg::reg_data_t       o_ctrl_wdata
);

    logic                 accept;
    logic                 wr;
    logic                 rd;
    sdspi_pkg::reg_data_t rdata;

    assign o_req_ready = ~o_resp_valid | i_resp_ready;     // stall only on a held response
    assign accept      = i_req_valid & o_req_ready;
    assign wr          = accept & i_req_write;
    assign rd          = accept & ~i_req_write;

    assign o_tx_push    = wr & (i_req_addr == `SDSPI_ADDR_TXDATA);
    assign o_tx_data    = i_req_wdata[7:0];
    assign o_rx_pop     = rd & (i_req_addr == `SDSPI_ADDR_RXDATA);
    assign o_scaler_we  = wr & (i_req_addr == `SDSPI_ADDR_SCALER);
    assign o_ctrl_we    = wr & (i_req_addr == `SDSPI_ADDR_CTRL);
    assign o_ctrl_wdata = i_req_wdata;

    always_comb begin
        rdata = '0;
        case (i_req_addr)
            `SDSPI_ADDR_SCALER: rdata[15:0] = o_scaler;
            `SDSPI_ADDR_WDOG:   rdata[15:0] = o_wdog;
            `SDSPI_ADDR_CTRL: begin
                rdata[6:4]   = i_state;
                rdata[7]     = i_gen_crc;
                rdata[8]     = i_rx_ena;
                rdata[9]     = i_rx_synced;
                rdata[31:16] = i_bytes_left;
            end
            `SDSPI_ADDR_TXDATA: rdata[31] = i_tx_full;
            `SDSPI_ADDR_RXDATA: begin
                rdata[7:0] = i_rx_head;                    // show-ahead head, popped on accept
                rdata[31]  = i_rx_empty;
            end
            default: rdata = '0;
        endcase
    end

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            o_scaler     <= '0;
            o_wdog       <= '0;
            o_resp_valid <= 1'b0;
        end else begin
            if (o_scaler_we) begin
                o_scaler <= i_req_wdata[15:0];
            end
            if (wr && (i_req_addr == `SDSPI_ADDR_WDOG)) begin
                o_wdog <= i_req_wdata[15:0];
            end
            if (accept) begin
                o_resp_valid <= 1'b1;
            end else if (i_resp_ready) begin
                o_resp_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (accept) begin
            o_resp_rdata <= rdata;                         // held until taken
        end
    end

endmodule

`default_nettype wire

// File: design/sdspi_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "sdspi_params.svh"

module sdspi_top (
    input  wire                       i_clk,
    input  wire                       i_nrst,
    input  wire                       i_req_valid,
    input  wire sdspi_pkg::reg_addr_t i_req_addr,
    input  wire                       i_req_write,
    input  wire sdspi_pkg::reg_data_t i_req_wdata,
    output logic                      o_req_ready,
    output logic                      o_resp_valid,
    output sdspi_pkg::reg_data_t      o_resp_rdata,
    input  wire                       i_resp_ready,
    output logic                      o_sclk,
    output logic                      o_mosi,
    input  wire                       i_miso,
    output logic                      o_cs_n
);

    logic                   tx_push;
    sdspi_pkg::byte_t       tx_data;
    sdspi_pkg::byte_t       tx_head;
    logic                   tx_empty;
    logic                   tx_full;
    logic                   tx_pop;
    logic                   rx_push;
    sdspi_pkg::byte_t       rx_data;
    sdspi_pkg::byte_t       rx_head;
    logic                   rx_empty;
    logic                   rx_pop;
    sdspi_pkg::scaler_t     scaler;
    logic                   scaler_we;
    sdspi_pkg::wdog_t       wdog;
    logic                   ctrl_we;
    sdspi_pkg::reg_data_t   ctrl_wdata;
    sdspi_pkg::spi_state_t  state;
    sdspi_pkg::byte_cnt_t   bytes_left;
    logic                   gen_crc;
    logic                   rx_ena;
    logic                   rx_synced;
    logic                   sclk_level;
    logic                   sclk_rise;
    logic                   sclk_fall;

    sdspi_regs u_regs (
        .i_clk        (i_clk),
        .i_nrst       (i_nrst),
        .i_req_valid  (i_req_valid),
        .i_req_addr   (i_req_addr),
        .i_req_write  (i_req_write),
        .i_req_wdata  (i_req_wdata),
        .o_req_ready  (o_req_ready),
        .o_resp_valid (o_resp_valid),
        .o_resp_rdata (o_resp_rdata),
        .i_resp_ready (i_resp_ready),
        .i_tx_full    (tx_full),
        .i_rx_head    (rx_head),
        .i_rx_empty   (rx_empty),
        .i_state      (state),
        .i_bytes_left (bytes_left),
        .i_gen_crc    (gen_crc),
        .i_rx_ena     (rx_ena),
        .i_rx_synced  (rx_synced),
        .o_tx_push    (tx_push),
        .o_tx_data    (tx_data),
        .o_rx_pop     (rx_pop),
        .o_scaler     (scaler),
        .o_scaler_we  (scaler_we),
        .o_wdog       (wdog),
        .o_ctrl_we    (ctrl_we),
        .o_ctrl_wdata (ctrl_wdata)
    );

    byte_fifo #(.LOG2_DEPTH(`SDSPI_FIFO_LOG2)) u_tx_fifo (
        .i_clk   (i_clk),
        .i_nrst  (i_nrst),
        .i_push  (tx_push),
        .i_wdata (tx_data),
        .i_pop   (tx_pop),
        .o_rdata (tx_head),
        .o_empty (tx_empty),
        .o_full  (tx_full),
        .o_count ()
    );

    byte_fifo #(.LOG2_DEPTH(`SDSPI_FIFO_LOG2)) u_rx_fifo (
        .i_clk   (i_clk),
        .i_nrst  (i_nrst),
        .i_push  (rx_push),     // dropped inside when full
        .i_wdata (rx_data),
        .i_pop   (rx_pop),
        .o_rdata (rx_head),
        .o_empty (rx_empty),
        .o_full  (),
        .o_count ()
    );

    sclk_divider u_div (
        .i_clk     (i_clk),
        .i_nrst    (i_nrst),
        .i_scaler  (scaler),
        .i_restart (scaler_we),
        .o_level   (sclk_level),
        .o_rise    (sclk_rise),
        .o_fall    (sclk_fall)
    );

    spi_byte_engine u_engine (
        .i_clk        (i_clk),
        .i_nrst       (i_nrst),
        .i_rise       (sclk_rise),
        .i_fall       (sclk_fall),
        .i_level      (sclk_level),
        .i_ctrl_we    (ctrl_we),
        .i_ctrl_wdata (ctrl_wdata),
        .i_wdog       (wdog),
        .i_tx_data    (tx_head),
        .i_tx_valid   (~tx_empty),
        .i_miso       (i_miso),
        .o_tx_pop     (tx_pop),
        .o_rx_push    (rx_push),
        .o_rx_data    (rx_data),
        .o_state      (state),
        .o_bytes_left (bytes_left),
        .o_gen_crc    (gen_crc),
        .o_rx_ena     (rx_ena),
        .o_rx_synced  (rx_synced),
        .o_sclk       (o_sclk),
        .o_mosi       (o_mosi),
        .o_cs_n       (o_cs_n)
    );

endmodule

`default_nettype wire

// File: tb/tb_clkgen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen (
    output logic o_clk,
    output logic o_nrst
);

    initial begin
        o_clk = 1'b0;
        forever #2 o_clk = ~o_clk;                 // 4 ns period
    end

    initial begin
        o_nrst = 1'b0;
        repeat (3) @(posedge o_clk);
        @(negedge o_clk);                          // release away from the active edge
        o_nrst = 1'b1;
    end

endmodule

`default_nettype wire

// File: tb/sd_card_model.sv
`timescale 1ns/1ps
`default_nettype none

module sd_card_model (
    input  wire              i_sclk,
    input  wire              i_mosi,
    input  wire              i_cs_n,
    output logic             o_miso,
    output logic [15:0]      o_cap_count,
    output sdspi_pkg::byte_t o_cap_byte
);

    logic             miso_q [$];
    sdspi_pkg::byte_t cap_shift;
    int               cap_bits;

    initial begin
        o_miso      = 1'b1;
        o_cap_count = '0;
        o_cap_byte  = '0;
        cap_shift   = '0;
        cap_bits    = 0;
    end

    // queue one byte for the card to answer with, msb first
    task automatic queue_miso_byte(input sdspi_pkg::byte_t b);
        int i;
        for (i = 7; i >= 0; i--) begin
            miso_q.push_back(b[i]);
        end
    endtask

    task drive_next_bit();
        if (miso_q.size() > 0) begin
            o_miso = miso_q.pop_front();
        end else begin
            o_miso = 1'b1;                          // card idles high
        end
    endtask

    always @(negedge i_cs_n) begin
        cap_bits = 0;                               // bytes align to the select
        drive_next_bit();
    end

    always @(posedge i_cs_n) begin
        o_miso = 1'b1;
    end

    always @(negedge i_sclk) begin
        if (i_cs_n == 1'b0) begin
            drive_next_bit();
        end
    end

    always @(posedge i_sclk) begin
        if (i_cs_n == 1'b0) begin
            cap_shift = {cap_shift[6:0], i_mosi};
            cap_bits  = cap_bits + 1;
            if (cap_bits == 8) begin
                cap_bits    = 0;
                o_cap_byte  = cap_shift;
                o_cap_count = o_cap_count + 16'd1;  // byte last, count after it
            end
        end
    end

endmodule

`default_nettype wire

// File: tb/tb_sdspi.sv
`timescale 1ns/1ps
`default_nettype none

`include "sdspi_params.svh"

module tb_sdspi;

    localparam int WAIT_LIMIT = 100;
    localparam int POLL_LIMIT = 2000;

    logic                 clk;
    logic                 nrst;
    logic                 req_valid;
    logic                 req_write;
    logic                 resp_ready;
    sdspi_pkg::reg_addr_t req_addr;
    sdspi_pkg::reg_data_t req_wdata;
    sdspi_pkg::reg_data_t resp_rdata;
    logic                 req_ready;
    logic                 resp_valid;
    logic                 sclk;
    logic                 mosi;
    logic                 miso;
    logic                 cs_n;
    logic [15:0]          cap_count;
    logic [15:0]          cap_seen;
    sdspi_pkg::byte_t     cap_byte;
    sdspi_pkg::byte_t     exp_q [$];
    logic                 compare_on;
    logic [31:0]          lcg_state;
    int                   errors;
    int                   checks;
    int                   tests;

    tb_clkgen u_clk (.o_clk(clk), .o_nrst(nrst));

    sdspi_top u_dut (
        .i_clk        (clk),
        .i_nrst       (nrst),
        .i_req_valid  (req_valid),
        .i_req_addr   (req_addr),
        .i_req_write  (req_write),
        .i_req_wdata  (req_wdata),
        .o_req_ready  (req_ready),
        .o_resp_valid (resp_valid),
        .o_resp_rdata (resp_rdata),
        .i_resp_ready (resp_ready),
        .o_sclk       (sclk),
        .o_mosi       (mosi),
        .i_miso       (miso),
        .o_cs_n       (cs_n)
    );

    sd_card_model u_card (
        .i_sclk      (sclk),
        .i_mosi      (mosi),
        .i_cs_n      (cs_n),
        .o_miso      (miso),
        .o_cap_count (cap_count),
        .o_cap_byte  (cap_byte)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic sdspi_pkg::byte_t rand_byte();
        lcg_state = lcg_next(lcg_state);
        return lcg_state[23:16];
    endfunction

    // CRC7 with x^7 + x^3 + 1 over one byte msb first
    function automatic sdspi_pkg::crc7_t crc7_ref(input sdspi_pkg::crc7_t crc,
                                                  input sdspi_pkg::byte_t b);
        sdspi_pkg::crc7_t c;
        logic             fb;
        int               i;
        c = crc;
        for (i = 7; i >= 0; i--) begin
            fb = c[6] ^ b[i];
            c  = {c[5:0], 1'b0};
            if (fb) begin
                c = c ^ 7'h09;
            end
        end
        return c;
    endfunction

    task automatic check_byte(input sdspi_pkg::byte_t got, input sdspi_pkg::byte_t exp,
                              input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t ns: %s got %02h expected %02h", $time, what, got, exp);
        end
    endtask

    task automatic check_reg(input sdspi_pkg::reg_data_t got, input sdspi_pkg::reg_data_t exp,
                             input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t ns: %s got %08h expected %08h", $time, what, got, exp);
        end
    endtask

    task automatic abort_timeout(input string what);
        $display("timeout at %0t ns while waiting for %s", $time, what);
        $display("Testbench failed");
        $finish;
    endtask

    task automatic reg_xfer(input logic wr, input sdspi_pkg::reg_addr_t addr,
                            input sdspi_pkg::reg_data_t wdata,
                            output sdspi_pkg::reg_data_t rdata);
        int t;
        @(negedge clk);
        req_valid = 1'b1;
        req_write = wr;
        req_addr  = addr;
        req_wdata = wdata;
        t = 0;
        while (!req_ready && t < WAIT_LIMIT) begin
            @(negedge clk);
            t++;
        end
        if (!req_ready) abort_timeout("request accept");
        @(negedge clk);                             // accepted on the edge before
        req_valid = 1'b0;
        t = 0;
        while (!resp_valid && t < WAIT_LIMIT) begin
            @(negedge clk);
            t++;
        end
        if (!resp_valid) abort_timeout("register response");
        rdata = resp_rdata;
    endtask

    task automatic reg_write(input sdspi_pkg::reg_addr_t a, input sdspi_pkg::reg_data_t d);
        sdspi_pkg::reg_data_t unused;
        reg_xfer(1'b1, a, d, unused);
    endtask

    task automatic reg_read(input sdspi_pkg::reg_addr_t a, output sdspi_pkg::reg_data_t d);
        reg_xfer(1'b0, a, '0, d);
    endtask

    // transfer is over when CTRL shows idle with no bytes left
    task automatic wait_done();
        sdspi_pkg::reg_data_t r;
        int                   t;
        t = 0;
        reg_read(`SDSPI_ADDR_CTRL, r);
        while ((r[6:4] != 3'd0 || r[31:16] != 16'd0) && t < POLL_LIMIT) begin
            reg_read(`SDSPI_ADDR_CTRL, r);
            t++;
        end
        if (r[6:4] != 3'd0 || r[31:16] != 16'd0) abort_timeout("end of transfer");
    endtask

    task automatic run_tx(input int n_push, input int count, input logic gen_crc);
        sdspi_pkg::byte_t b;
        sdspi_pkg::crc7_t crc;
        int               i;
        crc = '0;
        for (i = 0; i < count; i++) begin
            if (i < n_push) begin
                b = rand_byte();
                reg_write(`SDSPI_ADDR_TXDATA, {24'd0, b});
            end else begin
                b = 8'hFF;                          // FIFO ran dry
            end
            exp_q.push_back(b);
            crc = crc7_ref(crc, b);
        end
        if (gen_crc) begin
            exp_q.push_back({crc, 1'b1});
        end
        compare_on = 1'b1;
        reg_write(`SDSPI_ADDR_CTRL, {count[15:0], 6'd0, 1'b0, 1'b0, gen_crc, 7'd0});
        wait_done();
        if (exp_q.size() != 0) begin
            errors++;
            $display("%0d expected card bytes never arrived by %0t ns", exp_q.size(), $time);
            exp_q.delete();
        end
        compare_on = 1'b0;
    endtask

    task automatic end_test(input int num, input string name, input int err_before);
        tests++;
        $display("test %0d %s: %s", num, name, (errors == err_before) ? "ok" : "FAILED");
    endtask

    // compares each byte the card captures against the expected queue
    always @(negedge clk) begin
        if (cap_count != cap_seen) begin
            cap_seen = cap_count;
            if (compare_on) begin
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("card got an extra byte %02h at %0t ns", cap_byte, $time);
                end else begin
                    check_byte(cap_byte, exp_q.pop_front(), "card byte");
                end
            end
        end
    end

    initial begin
        sdspi_pkg::reg_data_t r;
        sdspi_pkg::byte_t     rx_bytes [4];
        int                   i;
        int                   t;
        int                   err_before;
        req_valid  = 1'b0;
        req_write  = 1'b0;
        req_addr   = '0;
        req_wdata  = '0;
        resp_ready = 1'b1;
        compare_on = 1'b0;
        cap_seen   = '0;
        lcg_state  = 32'heed38ca6;
        errors     = 0;
        checks     = 0;
        tests      = 0;
        t = 0;
        while (nrst !== 1'b1 && t < WAIT_LIMIT) begin
            @(negedge clk);
            t++;
        end
        if (nrst !== 1'b1) abort_timeout("reset release");

        err_before = errors;
        check_reg({27'd0, cs_n, sclk, mosi, req_ready, resp_valid}, 32'h16, "pins after reset");
        reg_read(`SDSPI_ADDR_CTRL, r);
        check_reg(r, 32'h0, "CTRL after reset");
        reg_write(`SDSPI_ADDR_SCALER, 32'h0000_1234);
        reg_read(`SDSPI_ADDR_SCALER, r);
        check_reg(r, 32'h0000_1234, "SCALER readback");
        reg_write(`SDSPI_ADDR_WDOG, 32'h5A5A_BEEF);  // upper half not stored
        reg_read(`SDSPI_ADDR_WDOG, r);
        check_reg(r, 32'h0000_BEEF, "WDOG readback");
        reg_write(`SDSPI_ADDR_SCALER, 32'd2);
        end_test(1, "register readback", err_before);

        err_before = errors;
        run_tx(6, 6, 1'b0);
        end_test(2, "transmit", err_before);

        err_before = errors;
        run_tx(2, 4, 1'b0);
        end_test(3, "empty fifo idle bytes", err_before);

        err_before = errors;
        run_tx(3, 3, 1'b1);
        end_test(4, "crc append", err_before);

        err_before = errors;
        reg_write(`SDSPI_ADDR_WDOG, 32'd0);          // wait for the start bit forever
        u_card.queue_miso_byte(8'hFF);
        for (i = 0; i < 4; i++) begin
            rx_bytes[i] = rand_byte();
            if (i == 0) begin
                rx_bytes[i][7] = 1'b0;               // start bit
            end
            u_card.queue_miso_byte(rx_bytes[i]);
        end
        reg_write(`SDSPI_ADDR_CTRL, {16'd4, 6'd0, 1'b0, 1'b1, 1'b0, 7'd0});
        wait_done();
        for (i = 0; i < 4; i++) begin
            reg_read(`SDSPI_ADDR_RXDATA, r);
            check_reg(r, {24'd0, rx_bytes[i]}, "RXDATA byte");
        end
        reg_read(`SDSPI_ADDR_RXDATA, r);
        check_reg(r & 32'h8000_0000, 32'h8000_0000, "RXDATA empty flag");
        end_test(5, "receive", err_before);

        err_before = errors;
        reg_write(`SDSPI_ADDR_WDOG, 32'd5);
        reg_write(`SDSPI_ADDR_CTRL, {16'd1, 6'd0, 1'b0, 1'b1, 1'b0, 7'd0});
        wait_done();
        reg_read(`SDSPI_ADDR_RXDATA, r);
        check_reg(r, 32'h0000_00FF, "watchdog RXDATA");
        end_test(6, "watchdog", err_before);

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+common
common/sdspi_pkg.sv
design/byte_fifo.sv
spi_engine/sclk_divider.sv
spi_engine/spi_byte_engine.sv
design/sdspi_regs.sv
design/sdspi_top.sv
tb/tb_clkgen.sv
tb/sd_card_model.sv
tb/tb_sdspi.sv
